// File: design/synth_pkg.sv
package synth_pkg;

    localparam int PHASE_W      = 24;   // phase accumulator width
    localparam int CREDIT_DEPTH = 2;    // i2s buffer entries = credits at reset

    typedef enum logic {
        note_off = 1'b0,                // 0x8n, or 0x9n with velocity 0
        note_on  = 1'b1                 // 0x9n, status bit 4 set
    } midi_op_e;

    typedef enum logic [1:0] {
        parse_idle,                     // no message open, running status may apply
        wait_data1,                     // note number expected
        wait_data2                      // velocity expected
    } parse_state_e;

    typedef enum logic [1:0] {
        uart_idle,
        uart_start,                     // start bit recheck at mid-bit
        uart_data,
        uart_stop
    } uart_state_e;

    // phase step per 48 kHz sample, notes 60 (C4) to 71 (B4)
    // step = f * 2^24 / 48000, other octaves are shifted copies
    localparam logic [PHASE_W-1:0] SEMITONE_INC [12] = '{
        24'd91445,                      // C
        24'd96882,                      // C#
        24'd102643,                     // D
        24'd108747,                     // D#
        24'd115213,                     // E
        24'd122064,                     // F
        24'd129322,                     // F#
        24'd137012,                     // G
        24'd145160,                     // G#
        24'd153791,                     // A 440 Hz
        24'd162936,                     // A#
        24'd172626                      // B
    };

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx
    import synth_pkg::*;
#(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 38400
) (
    input  logic       CLK_50M,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid,
    output logic       frame_error
);

    localparam int BIT_CNT  = CLK_FREQ / BAUD_RATE;    // clocks per bit
    localparam int HALF_CNT = BIT_CNT / 2;              // start edge to mid-bit
    localparam int CNT_W    = $clog2(BIT_CNT);

    uart_state_e      state;
    logic [2:0]       rx_sync;                          // [0] newest
    logic [CNT_W-1:0] cnt;                              // clocks to next sample point
    logic [2:0]       bit_idx;
    logic             rx_s;
    logic             rx_fall;
    logic             sample_pt;

    assign rx_s      = rx_sync[1];                      // after two flops
    assign rx_fall   = rx_sync[2] & ~rx_sync[1];        // edge only, a stuck-low line never restarts
    assign sample_pt = (cnt == '0);

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            rx_sync <= 3'b111;                          // idle line is high
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            state       <= uart_idle;
            cnt         <= '0;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;                        // strobes
            frame_error <= 1'b0;
            if (state != uart_idle && !sample_pt) begin
                cnt <= cnt - 1'b1;
            end
            case (state)
                uart_idle: begin
                    if (rx_fall) begin
                        state <= uart_start;
                        cnt   <= CNT_W'(HALF_CNT - 1);
                    end
                end
                uart_start: begin
                    if (sample_pt) begin
                        cnt     <= CNT_W'(BIT_CNT - 1);
                        bit_idx <= '0;
                        state   <= rx_s ? uart_idle : uart_data;   // glitch rejected
                    end
                end
                uart_data: begin
                    if (sample_pt) begin
                        cnt     <= CNT_W'(BIT_CNT - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_stop;
                        end
                    end
                end
                uart_stop: begin
                    if (sample_pt) begin
                        byte_valid  <= rx_s;            // good stop bit
                        frame_error <= ~rx_s;           // byte dropped
                        state       <= uart_idle;
                    end
                end
                default: state <= uart_idle;
            endcase
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (state == uart_data && sample_pt) begin
            byte_data <= {rx_s, byte_data[7:1]};        // lsb first
        end
    end

    a_cnt_in_bit: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        state != uart_idle |-> cnt < CNT_W'(BIT_CNT));

endmodule

// File: design/midi_parser.sv
`timescale 1ns/1ns

module midi_parser
    import synth_pkg::*;
(
    input  logic       CLK_50M,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic       ev_valid,
    output midi_op_e   ev_op,
    output logic [6:0] ev_note,
    output logic [6:0] ev_velocity
);

    parse_state_e state;
    logic         run_valid;                    // running status held
    midi_op_e     run_op;                       // op of last note status
    logic [6:0]   note_q;                       // first data byte
    logic         is_status;
    logic         is_note_status;
    logic         msg_done;
    logic         take_note;

    assign is_status      = byte_data[7];
    assign is_note_status = (byte_data[7:5] == 3'b100);     // 0x8n or 0x9n, any channel
    assign msg_done       = byte_valid && !is_status && state == wait_data2;
    assign take_note      = byte_valid && !is_status &&
                            (state == wait_data1 || (state == parse_idle && run_valid));

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            state     <= parse_idle;
            run_valid <= 1'b0;
            ev_valid  <= 1'b0;
        end else begin
            ev_valid <= msg_done;                           // one cycle after last byte
            if (byte_valid) begin
                if (is_status) begin
                    run_valid <= is_note_status;            // other status kills running status
                    state     <= is_note_status ? wait_data1 : parse_idle;
                end else if (take_note) begin
                    state <= wait_data2;
                end else if (msg_done) begin
                    state <= parse_idle;                    // next data byte reuses status
                end
            end
        end
    end

    // status op and first data byte
    always_ff @(posedge CLK_50M) begin
        if (byte_valid && is_status && is_note_status) begin
            run_op <= midi_op_e'(byte_data[4]);
        end
        if (take_note) begin
            note_q <= byte_data[6:0];
        end
    end

    // event payload, latched with the strobe
    always_ff @(posedge CLK_50M) begin
        if (msg_done) begin
            ev_note     <= note_q;
            ev_velocity <= byte_data[6:0];
            if (run_op == note_on && byte_data[6:0] != 7'd0) begin
                ev_op <= note_on;
            end else begin
                ev_op <= note_off;                          // vel 0 means off
            end
        end
    end

    a_ev_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        ev_valid |=> !ev_valid);

endmodule

// File: design/tone_voice.sv
`timescale 1ns/1ns

module tone_voice
    import synth_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                    CLK_50M,
    input  logic                    rst_n,
    input  logic                    ev_valid,
    input  midi_op_e                ev_op,
    input  logic [6:0]              ev_note,
    input  logic [6:0]              ev_velocity,
    input  logic                    credit_return,
    output logic                    sample_valid,
    output logic [SAMPLE_WIDTH-1:0] sample_data,
    output logic                    note_active
);

    localparam int MAG_SHIFT = SAMPLE_WIDTH - 8;    // vel 127 stays below full scale
    localparam int CNT_W     = $clog2(CREDIT_DEPTH + 1);

    logic [6:0]                     cur_note;
    logic [6:0]                     cur_vel;
    logic [PHASE_W-1:0]             phase;
    logic [PHASE_W-1:0]             inc;            // step of sounding note
    logic [PHASE_W-1:0]             inc_lookup;
    logic [3:0]                     semi;
    logic [3:0]                     octave;
    logic [CNT_W-1:0]               credit_cnt;
    logic                           take;
    logic signed [SAMPLE_WIDTH-1:0] mag;

    // table holds octave 5 (notes 60..71)
    always_comb begin
        semi   = 4'(ev_note % 7'd12);
        octave = 4'(ev_note / 7'd12);
        if (octave >= 4'd5) begin
            inc_lookup = SEMITONE_INC[semi] << (octave - 4'd5);
        end else begin
            inc_lookup = SEMITONE_INC[semi] >> (4'd5 - octave);
        end
    end

    assign mag  = SAMPLE_WIDTH'(cur_vel) << MAG_SHIFT;
    assign take = (credit_cnt != '0) || credit_return;  // returned credit used at once

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            note_active <= 1'b0;
            inc         <= '0;
        end else if (ev_valid) begin
            if (ev_op == note_on) begin
                note_active <= 1'b1;                    // last note wins
                inc         <= inc_lookup;
            end else if (ev_note == cur_note) begin
                note_active <= 1'b0;                    // off for other notes ignored
            end
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (ev_valid && ev_op == note_on) begin
            cur_note <= ev_note;
            cur_vel  <= ev_velocity;
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            credit_cnt   <= CNT_W'(CREDIT_DEPTH);       // buffer starts empty
            sample_valid <= 1'b0;
            phase        <= '0;
        end else begin
            sample_valid <= take;
            credit_cnt   <= credit_cnt + CNT_W'(credit_return) - CNT_W'(take);
            if (take) begin
                phase <= phase + inc;                   // held while out of credits
            end
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (take) begin
            if (!note_active) begin
                sample_data <= '0;
            end else if (phase[PHASE_W-1]) begin
                sample_data <= -mag;                    // low half of period
            end else begin
                sample_data <= mag;
            end
        end
    end

    a_credit_max: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        credit_cnt <= CNT_W'(CREDIT_DEPTH));

    a_return_has_sample: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        credit_return |-> credit_cnt < CNT_W'(CREDIT_DEPTH));

endmodule

// File: design/i2s_tx.sv
`timescale 1ns/1ns

module i2s_tx
    import synth_pkg::*;
#(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                    CLK_50M,
    input  logic                    rst_n,
    input  logic                    i2s_bclk,
    input  logic                    i2s_lrclk,
    input  logic                    sample_valid,
    input  logic [SAMPLE_WIDTH-1:0] sample_data,
    output logic                    credit_return,
    output logic                    i2s_sdata
);

    localparam int PTR_W = $clog2(CREDIT_DEPTH);        // depth is a power of two
    localparam int CNT_W = $clog2(CREDIT_DEPTH + 1);

    logic [2:0]              bclk_sync;                 // [2] is previous sample
    logic [1:0]              lrclk_sync;
    logic                    bclk_fall;
    logic                    lr_s;
    logic                    lr_last;                   // lrclk at previous bclk fall
    logic                    word_edge;
    logic                    frame_start;               // lrclk fell, left slot
    logic                    pop;
    logic [SAMPLE_WIDTH-1:0] fifo_mem [CREDIT_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        fifo_cnt;
    logic [SAMPLE_WIDTH-1:0] frame_sample;              // repeated in right slot
    logic [SAMPLE_WIDTH-1:0] shreg;
    logic [SAMPLE_WIDTH-1:0] next_word;

    assign bclk_fall   = bclk_sync[2] & ~bclk_sync[1];
    assign lr_s        = lrclk_sync[1];
    assign word_edge   = bclk_fall && (lr_s != lr_last);
    assign frame_start = word_edge && !lr_s;
    assign pop         = frame_start && (fifo_cnt != '0);

    // empty buffer at frame start sends silence
    always_comb begin
        if (lr_s) begin
            next_word = frame_sample;
        end else if (pop) begin
            next_word = fifo_mem[rd_ptr];
        end else begin
            next_word = '0;
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (sample_valid) begin
            fifo_mem[wr_ptr] <= sample_data;
        end
    end

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            bclk_sync     <= '0;
            lrclk_sync    <= '0;
            lr_last       <= 1'b0;
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_cnt      <= '0;
            credit_return <= 1'b0;
            i2s_sdata     <= 1'b0;
            shreg         <= '0;
            frame_sample  <= '0;
        end else begin
            bclk_sync     <= {bclk_sync[1:0], i2s_bclk};
            lrclk_sync    <= {lrclk_sync[0], i2s_lrclk};
            credit_return <= pop;                       // one credit per entry freed
            fifo_cnt      <= fifo_cnt + CNT_W'(sample_valid) - CNT_W'(pop);
            if (sample_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (frame_start) begin
                frame_sample <= next_word;
            end
            if (bclk_fall) begin
                lr_last   <= lr_s;
                i2s_sdata <= shreg[SAMPLE_WIDTH-1];     // msb lands one bclk after lrclk edge
                if (word_edge) begin
                    shreg <= next_word;
                end else begin
                    shreg <= shreg << 1;                // zero pad to end of slot
                end
            end
        end
    end

    a_no_push_full: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        !(sample_valid && fifo_cnt == CNT_W'(CREDIT_DEPTH)));

endmodule

// File: design/top.sv
`timescale 1ns/1ns

module top
    import synth_pkg::*;
#(
    parameter int CLK_FREQ     = 50_000_000,
    parameter int BAUD_RATE    = 38400,
    parameter int SAMPLE_WIDTH = 16             // 24 also works
) (
    input  logic       CLK_50M,
    input  logic       rst_n,
    input  logic       midi_in,
    input  logic       i2s_bclk,                // from codec
    input  logic       i2s_lrclk,               // from codec
    output logic       i2s_sdata,
    output logic [1:0] led
);

    logic [7:0]              byte_data;
    logic                    byte_valid;
    logic                    frame_error;
    logic                    ev_valid;
    midi_op_e                ev_op;
    logic [6:0]              ev_note;
    logic [6:0]              ev_velocity;
    logic                    sample_valid;
    logic [SAMPLE_WIDTH-1:0] sample_data;
    logic                    credit_return;
    logic                    note_active;
    logic                    err_seen;          // sticky until reset

    uart_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE)
    ) u_uart (
        .CLK_50M    (CLK_50M),
        .rst_n      (rst_n),
        .rx         (midi_in),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .frame_error(frame_error)
    );

    midi_parser u_parser (
        .CLK_50M    (CLK_50M),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .ev_valid   (ev_valid),
        .ev_op      (ev_op),
        .ev_note    (ev_note),
        .ev_velocity(ev_velocity)
    );

    tone_voice #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_voice (
        .CLK_50M      (CLK_50M),
        .rst_n        (rst_n),
        .ev_valid     (ev_valid),
        .ev_op        (ev_op),
        .ev_note      (ev_note),
        .ev_velocity  (ev_velocity),
        .credit_return(credit_return),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .note_active  (note_active)
    );

    i2s_tx #(
        .SAMPLE_WIDTH (SAMPLE_WIDTH)
    ) u_i2s (
        .CLK_50M      (CLK_50M),
        .rst_n        (rst_n),
        .i2s_bclk     (i2s_bclk),
        .i2s_lrclk    (i2s_lrclk),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .credit_return(credit_return),
        .i2s_sdata    (i2s_sdata)
    );

    always_ff @(posedge CLK_50M) begin
        if (!rst_n) begin
            err_seen <= 1'b0;
        end else if (frame_error) begin
            err_seen <= 1'b1;
        end
    end

    assign led = {err_seen, note_active};   // led1 uart error, led0 note sounding

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    localparam int CLK_FREQ   = 50_000_000;
    localparam int BAUD_RATE  = 38400;
    localparam int BIT_CLKS   = CLK_FREQ / BAUD_RATE;  // 1302 clocks per uart bit
    localparam int BCLK_HALF  = 8;                      // 64 bclk per frame, about 48.8 kHz
    localparam int FRAME_CLKS = 64 * 2 * BCLK_HALF;
    localparam int WIN        = 256;                    // frames per measurement

    logic       CLK_50M;
    logic       rst_n;
    logic       midi_in;
    logic       i2s_bclk;
    logic       i2s_lrclk;
    logic       i2s_sdata;
    logic [1:0] led;

    int          slot_bit;                  // bit position in current slot
    logic [15:0] cap_sr;                    // left word being rebuilt
    logic [15:0] last_word;                 // left word of latest frame
    int          frame_cnt;
    int          byte_events;
    int          ferr_events;
    int          errors;
    int          test_errs;
    int          tests;
    int          fails;
    logic        wait_failed;

    top #(
        .CLK_FREQ    (CLK_FREQ),
        .BAUD_RATE   (BAUD_RATE),
        .SAMPLE_WIDTH(16)
    ) u_dut (
        .CLK_50M  (CLK_50M),
        .rst_n    (rst_n),
        .midi_in  (midi_in),
        .i2s_bclk (i2s_bclk),
        .i2s_lrclk(i2s_lrclk),
        .i2s_sdata(i2s_sdata),
        .led      (led)
    );

    initial begin
        CLK_50M = 1'b0;
        forever #10 CLK_50M = ~CLK_50M;     // 50 MHz
    end

    // codec model, clocks change on falling system clock
    initial begin
        int ch;
        int b;
        i2s_bclk  = 1'b0;
        i2s_lrclk = 1'b1;                   // first fall opens a left slot
        slot_bit  = 0;
        forever begin
            for (ch = 0; ch < 2; ch++) begin
                for (b = 0; b < 32; b++) begin
                    i2s_bclk = 1'b0;
                    if (b == 0) begin
                        i2s_lrclk = ch[0];  // low = left
                    end
                    slot_bit = b;
                    repeat (BCLK_HALF) @(negedge CLK_50M);
                    i2s_bclk = 1'b1;
                    repeat (BCLK_HALF) @(negedge CLK_50M);
                end
            end
        end
    end

    // left word capture, msb one bclk after lrclk edge
    always @(posedge i2s_bclk) begin
        if (!i2s_lrclk && slot_bit >= 1 && slot_bit <= 16) begin
            cap_sr <= {cap_sr[14:0], i2s_sdata};
            if (slot_bit == 16) begin
                last_word <= {cap_sr[14:0], i2s_sdata};
                frame_cnt <= frame_cnt + 1;
            end
        end
    end

    // uart handshake seen inside the dut
    always @(posedge CLK_50M) begin
        if (u_dut.byte_valid) begin
            byte_events <= byte_events + 1;
        end
        if (u_dut.frame_error) begin
            ferr_events <= ferr_events + 1;
        end
    end

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic wait_frames(input int n, input string name);
        int target;
        int t;
        target = frame_cnt + n;
        t      = 0;
        while (frame_cnt < target && t < n * FRAME_CLKS * 2 + 100) begin
            @(negedge CLK_50M);
            t++;
        end
        if (frame_cnt < target) begin
            $display("timeout in %s: the codec frame did not arrive", name);
            wait_failed = 1'b1;
            count_error();
        end
    endtask

    // 8N1 lsb first, optional low stop bit
    task automatic send_byte(input string name, input logic [7:0] data, input logic bad_stop);
        int i;
        int t;
        int start_bytes;
        int start_ferr;
        start_bytes = byte_events;
        start_ferr  = ferr_events;
        midi_in     = 1'b0;                             // start bit
        repeat (BIT_CLKS) @(negedge CLK_50M);
        for (i = 0; i < 8; i++) begin
            midi_in = data[i];
            repeat (BIT_CLKS) @(negedge CLK_50M);
        end
        midi_in = ~bad_stop;
        repeat (BIT_CLKS) @(negedge CLK_50M);
        midi_in = 1'b1;                                 // back to idle
        t = 0;
        while (byte_events == start_bytes && ferr_events == start_ferr && t < 4 * BIT_CLKS) begin
            @(negedge CLK_50M);
            t++;
        end
        if (byte_events == start_bytes && ferr_events == start_ferr) begin
            $display("timeout in %s: UART byte 0x%02h was never taken by the DUT", name, data);
            count_error();
        end else if (bad_stop && ferr_events == start_ferr) begin
            $display("in %s: byte 0x%02h with a low stop bit was accepted", name, data);
            count_error();
        end else if (!bad_stop && byte_events == start_bytes) begin
            $display("in %s: byte 0x%02h was flagged as a framing error", name, data);
            count_error();
        end
        repeat (BIT_CLKS) @(negedge CLK_50M);           // idle gap
    endtask

    task automatic run_record(input string name, input int nbytes, input logic [31:0] bytes,
                              input logic bad_stop, input logic [15:0] exp_mag,
                              input logic [1:0] exp_led, input int min_sc, input int max_sc);
        int          i;
        int          sc;
        int          bad_words;
        logic [15:0] word;
        logic [15:0] mag_abs;
        logic [15:0] first_bad;
        logic        prev_sign;
        test_errs   = 0;
        wait_failed = 1'b0;
        for (i = 0; i < nbytes; i++) begin
            send_byte(name, bytes[8*i +: 8], bad_stop && i == 0);  // flag marks first byte
        end
        wait_frames(4, name);                           // old samples drain from the buffer
        if (led !== exp_led) begin
            $display("Fail %s: led expected %b actual %b", name, exp_led, led);
            count_error();
        end
        sc        = 0;
        bad_words = 0;
        first_bad = '0;
        prev_sign = last_word[15];
        for (i = 0; i < WIN; i++) begin
            wait_frames(1, name);
            if (wait_failed) begin
                break;
            end
            word    = last_word;
            mag_abs = word[15] ? -word : word;
            if (mag_abs != exp_mag) begin
                if (bad_words == 0) begin
                    first_bad = mag_abs;
                end
                bad_words++;
            end
            if (word[15] != prev_sign) begin
                sc++;                                   // square wave edge
            end
            prev_sign = word[15];
        end
        if (bad_words != 0) begin
            $display("Fail %s: magnitude expected 0x%04h actual 0x%04h in %0d words",
                     name, exp_mag, first_bad, bad_words);
            count_error();
        end
        if (sc < min_sc || sc > max_sc) begin
            $display("Fail %s: sign changes expected %0d to %0d actual %0d",
                     name, min_sc, max_sc, sc);
            count_error();
        end
        tests++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            fails++;
            $display("test %s: %0d errors", name, test_errs);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       name;
        int          nbytes;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [7:0]  b3;
        int          bad;
        logic [15:0] mag;
        logic [1:0]  exp_led;
        int          min_sc;
        int          max_sc;
        rst_n       = 1'b0;
        midi_in     = 1'b1;                             // uart idle
        cap_sr      = '0;
        last_word   = '0;
        frame_cnt   = 0;
        byte_events = 0;
        ferr_events = 0;
        errors      = 0;
        test_errs   = 0;
        tests       = 0;
        fails       = 0;
        wait_failed = 1'b0;
        repeat (2) @(negedge CLK_50M);
        rst_n = 1'b1;
        fd = $fopen("sim/midi_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/midi_trace.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() < 2 || line[0] == 8'h23) begin
                    continue;                           // blank or comment
                end
                n = $sscanf(line, "%s %d %h %h %h %h %d %h %b %d %d", name, nbytes,
                            b0, b1, b2, b3, bad, mag, exp_led, min_sc, max_sc);
                if (n != 11) begin
                    $display("malformed trace line: %s", line);
                    errors++;
                    continue;
                end
                run_record(name, nbytes, {b3, b2, b1, b0}, bad != 0, mag, exp_led,
                           min_sc, max_sc);
            end
            $fclose(fd);
        end
        if (tests == 0) begin
            $display("no test records were run");
            errors++;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests, fails, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim/midi_trace.txt
# name nbytes b0 b1 b2 b3 bad_stop magnitude led min_sign_changes max_sign_changes
# bytes and magnitude in hex, led in binary, bad_stop sends b0 with a low stop bit
reset_idle   0 00 00 00 00 0 0000 00 0 0
note_on_86   3 90 56 20 00 0 2000 01 11 14
run_status   2 45 40 00 00 0 4000 01 3 6
off_other    3 80 3c 00 00 0 4000 01 3 6
off_match    3 80 45 00 00 0 0000 00 0 0
on_again     3 90 3c 50 00 0 5000 01 1 4
vel_zero_off 2 3c 00 00 00 0 0000 00 0 0
on_for_err   3 90 48 30 00 0 3000 01 4 7
frame_err    1 80 00 00 00 1 3000 11 4 7
after_err    2 4c 20 00 00 0 2000 11 6 9

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

if ! verilator --binary -f files.f --top-module tb_top -o tb_top_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

exit 0

// File: files.f
design/synth_pkg.sv
design/uart_rx.sv
design/midi_parser.sv
design/tone_voice.sv
design/i2s_tx.sv
design/top.sv
sim/tb_top.sv
